// ==== filelist.f ====
+incdir+.
vcfg_pkg.sv
vset_decoder.sv
vector_csrs.sv
scalar_regfile.sv
wb_arbiter.sv
vcfg_top.sv
vcfg_assertions.sv
vcfg_tb.sv

// ==== Bender.yml ====
package:
  name: vcfg

export_include_dirs:
  - .

sources:
  - vcfg_pkg.sv
  - vset_decoder.sv
  - vector_csrs.sv
  - scalar_regfile.sv
  - wb_arbiter.sv
  - vcfg_top.sv
  - target: test
    files:
      - vcfg_assertions.sv
      - vcfg_tb.sv

// ==== vcfg_tb.sv ====
`default_nettype none

`include "vcfg_settings.svh"

module vcfg_tb;
    import vcfg_pkg::*;

    localparam int MAX_TESTS = 32;

    // One table row, name kept apart since strings cannot be packed
    typedef struct packed {
        logic        pre_valid;
        logic [4:0]  pre_reg;
        logic [31:0] pre_val;
        logic [31:0] instr;
        logic [31:0] exp_vl;
        logic [31:0] exp_vtype;
        logic [4:0]  rd;
        logic [31:0] exp_rd;
        logic        coll_valid;
        logic [4:0]  coll_reg;
        logic [31:0] coll_val;
    } tb_entry_t;

    logic        clk;
    logic        reset_n;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        host_wr_valid_i;
    logic [4:0]  host_addr_i;
    logic [31:0] host_data_i;
    logic [4:0]  dbg_addr_i;
    logic [31:0] dbg_data_o;
    logic [31:0] vl_o;
    logic [31:0] vtype_o;

    tb_entry_t   entries [MAX_TESTS];
    string       names [MAX_TESTS];
    int          n_tests;
    tb_entry_t   stage;

    // Reference model state while the table is built
    logic [31:0] m_regs [32];
    logic [31:0] m_vl;
    logic [31:0] m_vtype;

    integer      seed;
    int          error_count;
    int          passed;
    int          timeout_limit;
    int          cycle_count = 0;
    int unsigned assert_fails;

    vcfg_top dut_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .host_wr_valid_i (host_wr_valid_i),
        .host_addr_i     (host_addr_i),
        .host_data_i     (host_data_i),
        .dbg_addr_i      (dbg_addr_i),
        .dbg_data_o      (dbg_data_o),
        .vl_o            (vl_o),
        .vtype_o         (vtype_o)
    );

    always #2 clk = ~clk;

    // Run limit grows with the table
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("timeout: no result after %0d cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // VLMAX = LMUL * VLEN / SEW
    function automatic int unsigned vlmax_of(input logic [2:0] sew, input logic [2:0] lmul);
        int unsigned num;
        int unsigned den;
        num = 1;
        den = 1;
        case (lmul)
            3'd1:    num = 2;
            3'd2:    num = 4;
            3'd3:    num = 8;
            3'd4:    num = 0;
            3'd5:    den = 8;
            3'd6:    den = 4;
            3'd7:    den = 2;
            default: num = 1;
        endcase
        return (`VCFG_VLEN * num) / ((8 << sew) * den);
    endfunction

    function automatic bit cfg_legal(input logic [31:0] vt);
        if (vt[31:8] != 24'd0) return 1'b0;
        case (vt[2:0])
            3'd4:    return 1'b0;
            3'd5:    return vt[5:3] == 3'd0;
            3'd6:    return vt[5:3] <= 3'd1;
            3'd7:    return vt[5:3] != 3'd3;
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic [31:0] min_u(input logic [31:0] a, input logic [31:0] b);
        return (a < b) ? a : b;
    endfunction

    function automatic logic [10:0] zimm_of(input bit vma, input bit vta,
                                            input logic [2:0] sew, input logic [2:0] lmul);
        return {3'b000, vma, vta, sew, lmul};
    endfunction

    function automatic logic [31:0] enc_csrr(input logic [4:0] rd, input logic [11:0] csr);
        return {csr, 5'd0, 3'b010, rd, 7'b1110011};
    endfunction

    task automatic stage_preload(input logic [4:0] r, input logic [31:0] v);
        stage.pre_valid = 1'b1;
        stage.pre_reg   = r;
        stage.pre_val   = v;
        m_regs[r]       = v;
    endtask

    task automatic stage_collision(input logic [4:0] r, input logic [31:0] v);
        stage.coll_valid = 1'b1;
        stage.coll_reg   = r;
        stage.coll_val   = v;
    endtask

    task automatic finish_entry(input string name, input logic [31:0] instr,
                                input logic [4:0] rd, input logic [31:0] rd_val);
        stage.instr     = instr;
        stage.exp_vl    = m_vl;
        stage.exp_vtype = m_vtype;
        stage.rd        = rd;
        if (rd != 5'd0) m_regs[rd] = rd_val;
        // x0 keeps reading zero
        stage.exp_rd = m_regs[rd];
        if (stage.coll_valid) m_regs[stage.coll_reg] = stage.coll_val;
        entries[n_tests] = stage;
        names[n_tests]   = name;
        n_tests++;
        stage = '0;
    endtask

    // New vl and vtype by the AVL rules
    task automatic apply_vset(input string name, input logic [31:0] instr,
                              input logic [31:0] vt, input bit uimm_form,
                              input logic [4:0] rd, input logic [4:0] rs1);
        int unsigned vlmax;
        logic [31:0] avl;
        vlmax = vlmax_of(vt[5:3], vt[2:0]);
        if (!cfg_legal(vt)) begin
            m_vl    = 32'd0;
            m_vtype = 32'h8000_0000;
        end else begin
            if (uimm_form) avl = {27'd0, rs1};
            else if (rs1 == 5'd0 && rd != 5'd0) avl = vlmax;
            else if (rs1 == 5'd0) avl = m_vl;
            else avl = m_regs[rs1];
            m_vl    = min_u(avl, vlmax);
            m_vtype = {24'd0, vt[7:0]};
        end
        finish_entry(name, instr, rd, m_vl);
    endtask

    task automatic add_vsetvli(input string name, input logic [4:0] rd,
                               input logic [4:0] rs1, input logic [10:0] zimm);
        apply_vset(name, {1'b0, zimm, rs1, 3'b111, rd, 7'b1010111},
                   {21'd0, zimm}, 1'b0, rd, rs1);
    endtask

    // Only the low 10 immediate bits fit in the vsetivli encoding
    task automatic add_vsetivli(input string name, input logic [4:0] rd,
                                input logic [4:0] uimm, input logic [10:0] zimm);
        apply_vset(name, {2'b11, zimm[9:0], uimm, 3'b111, rd, 7'b1010111},
                   {22'd0, zimm[9:0]}, 1'b1, rd, uimm);
    endtask

    task automatic add_vsetvl(input string name, input logic [4:0] rd,
                              input logic [4:0] rs1, input logic [4:0] rs2);
        apply_vset(name, {7'b1000000, rs2, rs1, 3'b111, rd, 7'b1010111},
                   m_regs[rs2], 1'b0, rd, rs1);
    endtask

    // CSR reads leave the configuration alone
    task automatic add_csr_read(input string name, input logic [4:0] rd, input logic [11:0] csr);
        logic [31:0] val;
        case (csr)
            12'hC20: val = m_vl;
            12'hC21: val = m_vtype;
            default: val = 32'(`VCFG_VLENB);
        endcase
        finish_entry(name, enc_csrr(rd, csr), rd, val);
    endtask

    task automatic build_table();
        logic [31:0] avl;
        n_tests = 0;
        stage   = '0;
        m_vl    = 32'd0;
        m_vtype = 32'd0;
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = 32'd0;
        end
        stage_preload(5'd5, 32'd3);
        add_vsetvli("vsetvli_avl_kept", 5'd10, 5'd5, zimm_of(0, 0, EW16, LMUL_2));
        stage_preload(5'd6, 32'd100);
        add_vsetvli("vsetvli_avl_clamped", 5'd11, 5'd6, zimm_of(0, 0, EW32, LMUL_1));
        stage_preload(5'd7, 32'd50);
        add_vsetvli("vsetvli_m8", 5'd12, 5'd7, zimm_of(0, 0, EW8, LMUL_8));
        for (int k = 0; k < 3; k++) begin
            avl = $unsigned($random(seed)) % 80;
            stage_preload(5'd8, avl);
            add_vsetvli($sformatf("vsetvli_random_%0d", k), 5'd13, 5'd8,
                        zimm_of(0, 0, EW8, LMUL_4));
        end
        add_vsetivli("vsetivli_kept", 5'd14, 5'd5, zimm_of(0, 0, EW8, LMUL_1));
        add_vsetivli("vsetivli_clamped", 5'd15, 5'd31, zimm_of(0, 0, EW16, LMUL_2));
        stage_preload(5'd9, {24'd0, 8'(zimm_of(1, 1, EW16, LMUL_4))});
        add_vsetvl("vsetvl_ta_ma", 5'd16, 5'd5, 5'd9);
        add_vsetvli("rs1_zero_vlmax", 5'd17, 5'd0, zimm_of(0, 0, EW8, LMUL_8));
        add_vsetvli("keep_vl_capped", 5'd0, 5'd0, zimm_of(0, 0, EW8, LMUL_1));
        add_vsetvli("keep_vl", 5'd0, 5'd0, zimm_of(0, 1, EW8, LMUL_2));
        add_csr_read("read_vl", 5'd18, 12'hC20);
        add_csr_read("read_vtype", 5'd19, 12'hC21);
        add_csr_read("read_vlenb", 5'd20, 12'hC22);
        add_vsetvli("illegal_mf8_e16", 5'd21, 5'd5, zimm_of(0, 0, EW16, LMUL_1_8));
        add_csr_read("read_vtype_vill", 5'd22, 12'hC21);
        add_vsetvli("illegal_rsvd_lmul", 5'd23, 5'd6, zimm_of(0, 0, EW8, LMUL_RSVD));
        add_vsetvli("legal_again", 5'd24, 5'd7, zimm_of(0, 0, EW64, LMUL_1));
        add_vsetvli("illegal_mf2_e64", 5'd25, 5'd7, zimm_of(0, 0, EW64, LMUL_1_2));
        add_vsetvli("legal_mf4_e16", 5'd24, 5'd7, zimm_of(0, 0, EW16, LMUL_1_4));
        stage_preload(5'd26, 32'h8000_0000 | 32'(zimm_of(0, 0, EW8, LMUL_1)));
        add_vsetvl("illegal_vsetvl_bit31", 5'd27, 5'd5, 5'd26);
        add_vsetvli("illegal_imm_rsvd", 5'd30, 5'd5, 11'h100 | zimm_of(0, 0, EW8, LMUL_1));
        stage_collision(5'd29, 32'h1234_5678);
        add_vsetvli("host_collision", 5'd28, 5'd5, zimm_of(0, 0, EW8, LMUL_1));
        add_csr_read("read_vl_final", 5'd31, 12'hC20);
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s %s: expected 0x%08h, actual 0x%08h",
                     test, what, expected, actual);
            error_count++;
        end
    endtask

    // Preload, two idle cycles, strobe, then checks at fixed latencies
    task automatic run_entry(input int idx);
        tb_entry_t e;
        int        errs_before;
        e           = entries[idx];
        errs_before = error_count;
        if (e.pre_valid) begin
            host_wr_valid_i = 1'b1;
            host_addr_i     = e.pre_reg;
            host_data_i     = e.pre_val;
            @(negedge clk);
            host_wr_valid_i = 1'b0;
        end
        repeat (2) @(negedge clk);
        instr_valid_i = 1'b1;
        instr_i       = e.instr;
        dbg_addr_i    = e.rd;
        @(negedge clk);
        instr_valid_i = 1'b0;
        instr_i       = 32'd0;
        check_value(names[idx], "vl", e.exp_vl, vl_o);
        check_value(names[idx], "vtype", e.exp_vtype, vtype_o);
        // Host write lands with the CSR writeback at the arbiter
        if (e.coll_valid) begin
            host_wr_valid_i = 1'b1;
            host_addr_i     = e.coll_reg;
            host_data_i     = e.coll_val;
        end
        @(negedge clk);
        host_wr_valid_i = 1'b0;
        @(negedge clk);
        check_value(names[idx], "rd", e.exp_rd, dbg_data_o);
        if (e.coll_valid) begin
            dbg_addr_i = e.coll_reg;
            @(negedge clk);
            check_value(names[idx], "host register", e.coll_val, dbg_data_o);
        end
        if (error_count == errs_before) begin
            passed++;
            $display("%s: ok", names[idx]);
        end else begin
            $display("%s: wrong values", names[idx]);
        end
    endtask

    initial begin
        clk             = 1'b0;
        reset_n         = 1'b0;
        instr_valid_i   = 1'b0;
        instr_i         = 32'd0;
        host_wr_valid_i = 1'b0;
        host_addr_i     = 5'd0;
        host_data_i     = 32'd0;
        dbg_addr_i      = 5'd0;
        error_count     = 0;
        passed          = 0;
        timeout_limit   = 0;
        seed            = 96;
        build_table();
        timeout_limit = 10 * n_tests + 50;
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < n_tests; i++) begin
            run_entry(i);
        end
        assert_fails = dut_i.csrs_i.asrt_i.failures;
        $display("tests %0d, passed %0d, mismatches %0d, assertion failures %0d",
                 n_tests, passed, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vcfg_assertions.sv ====
`default_nettype none

`include "vcfg_settings.svh"

module vcfg_assertions (
    input logic              clk,
    input logic              reset_n,
    input logic              vill_i,
    input logic [31:0]       vl_i,
    input logic [31:0]       vtype_i,
    input vcfg_pkg::wb_req_t wb_i
);

    // Running count of assertion failures
    int unsigned failures = 0;

    // vill forces vl to zero and vtype to its illegal readback
    vill_clears_cfg: assert property (@(posedge clk) disable iff (!reset_n)
        vill_i |-> (vl_i == 32'd0 && vtype_i == 32'h8000_0000))
    else begin
        failures++;
        $error("vill set with vl 0x%08h and vtype 0x%08h", vl_i, vtype_i);
    end

    // Largest VLMAX is LMUL 8 at SEW 8, which is VLEN elements
    vl_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        vl_i <= 32'(`VCFG_VLEN))
    else begin
        failures++;
        $error("vl 0x%08h above the largest VLMAX", vl_i);
    end

    // Register-file write port from the arbiter never targets x0
    no_x0_write: assert property (@(posedge clk) disable iff (!reset_n)
        wb_i.valid |-> (wb_i.addr != 5'd0))
    else begin
        failures++;
        $error("valid register-file write to x0");
    end

endmodule

bind vector_csrs vcfg_assertions asrt_i (
    .clk     (clk),
    .reset_n (reset_n),
    .vill_i  (vill_q),
    .vl_i    (vl_o),
    .vtype_i (vtype_o),
    .wb_i    (arb_i.wr_o)
);

`default_nettype wire

// ==== vcfg_top.sv ====
`default_nettype none

module vcfg_top (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic        host_wr_valid_i,
    input  logic [4:0]  host_addr_i,
    input  logic [31:0] host_data_i,
    input  logic [4:0]  dbg_addr_i,
    output logic [31:0] dbg_data_o,
    output logic [31:0] vl_o,
    output logic [31:0] vtype_o
);
    import vcfg_pkg::*;

    // Operand read path
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    vcfg_op_t    dec_op;
    wb_req_t     csr_req;
    wb_req_t     host_req;
    wb_req_t     rf_wr;

    // Host strobe as a write request
    assign host_req = '{valid: host_wr_valid_i, addr: host_addr_i, data: host_data_i};

    vset_decoder dec_i (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .op_o          (dec_op)
    );

    vector_csrs csrs_i (
        .clk     (clk),
        .reset_n (reset_n),
        .op_i    (dec_op),
        .wb_o    (csr_req),
        .vl_o    (vl_o),
        .vtype_o (vtype_o)
    );

    wb_arbiter arb_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .csr_req_i  (csr_req),
        .host_req_i (host_req),
        .wr_o       (rf_wr)
    );

    scalar_regfile rf_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .wr_i       (rf_wr),
        .ra_addr_i  (rs1_addr),
        .rb_addr_i  (rs2_addr),
        .ra_data_o  (rs1_data),
        .rb_data_o  (rs2_data),
        .dbg_addr_i (dbg_addr_i),
        .dbg_data_o (dbg_data_o)
    );

endmodule

`default_nettype wire

// ==== wb_arbiter.sv ====
`default_nettype none

module wb_arbiter (
    input  logic              clk,
    input  logic              reset_n,
    input  vcfg_pkg::wb_req_t csr_req_i,
    input  vcfg_pkg::wb_req_t host_req_i,
    output vcfg_pkg::wb_req_t wr_o
);
    import vcfg_pkg::*;

    wb_req_t pend_q;
    wb_req_t pend_next;
    wb_req_t host_cand;
    wb_req_t win;
    wb_req_t wr_q;

    // Held host write goes before a fresh one
    assign host_cand = pend_q.valid ? pend_q : host_req_i;

    always_comb begin
        if (csr_req_i.valid) begin
            // CSR unit wins, host candidate waits
            win       = csr_req_i;
            pend_next = host_cand;
        end else if (pend_q.valid) begin
            // Drain slot, park any new host write
            win       = pend_q;
            pend_next = host_req_i;
        end else begin
            win       = host_req_i;
            pend_next = '0;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pend_q <= '0;
            wr_q   <= '0;
        end else begin
            pend_q <= pend_next;
            wr_q   <= win;
        end
    end

    // Registered write port
    assign wr_o = wr_q;

endmodule

`default_nettype wire

// ==== scalar_regfile.sv ====
`default_nettype none

`include "vcfg_settings.svh"

module scalar_regfile (
    input  logic              clk,
    input  logic              reset_n,
    input  vcfg_pkg::wb_req_t wr_i,
    input  logic [4:0]        ra_addr_i,
    input  logic [4:0]        rb_addr_i,
    output logic [31:0]       ra_data_o,
    output logic [31:0]       rb_data_o,
    input  logic [4:0]        dbg_addr_i,
    output logic [31:0]       dbg_data_o
);

    logic [31:0] regs_q [`VCFG_NREGS];

    // x0 is never written, so it reads zero after reset
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `VCFG_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.valid && wr_i.addr != 5'd0) begin
            regs_q[wr_i.addr] <= wr_i.data;
        end
    end

    // Combinational reads, no bypass
    assign ra_data_o  = regs_q[ra_addr_i];
    assign rb_data_o  = regs_q[rb_addr_i];
    // Observation port
    assign dbg_data_o = regs_q[dbg_addr_i];

endmodule

`default_nettype wire

// ==== vector_csrs.sv ====
`default_nettype none

`include "vcfg_settings.svh"

module vector_csrs (
    input  logic               clk,
    input  logic               reset_n,
    input  vcfg_pkg::vcfg_op_t op_i,
    output vcfg_pkg::wb_req_t  wb_o,
    output logic [31:0]        vl_o,
    output logic [31:0]        vtype_o
);
    import vcfg_pkg::*;

    // Candidate configuration
    logic [31:0] vtype_src;
    vew_e        vsew_next;
    vlmul_e      vlmul_next;
    logic        vta_next;
    logic        vma_next;
    logic        ratio_err;
    logic        rsvd_err;
    logic        cfg_err;
    logic [31:0] elems_per_reg;
    logic [31:0] vlmax;
    logic [31:0] avl;
    logic [31:0] vl_next;
    logic        is_vset;
    logic [31:0] wb_data;

    // Architectural state
    vew_e        vsew_q;
    vlmul_e      vlmul_q;
    logic        vta_q;
    logic        vma_q;
    logic        vill_q;
    logic [31:0] vl_q;

    // Writeback register
    logic        wb_valid_q;
    logic [4:0]  wb_addr_q;
    logic [31:0] wb_data_q;

    assign is_vset = op_i.op inside {VSETVLI, VSETIVLI, VSETVL};

    // vsetvl takes vtype from rs2, others from zero-extended imm
    assign vtype_src  = (op_i.op == VSETVL) ? op_i.rs2_val : {21'b0, op_i.imm};
    assign vma_next   = vtype_src[7];
    assign vta_next   = vtype_src[6];
    assign vsew_next  = vew_e'(vtype_src[5:3]);
    assign vlmul_next = vlmul_e'(vtype_src[2:0]);

    // Any set bit above vma is reserved, bit 31 included
    assign rsvd_err = |vtype_src[31:8];

    // SEW/LMUL pairs with less than one element
    always_comb begin
        case (vlmul_next)
            LMUL_1_8:  ratio_err = vsew_next inside {EW16, EW32, EW64};
            LMUL_1_4:  ratio_err = vsew_next inside {EW32, EW64};
            LMUL_1_2:  ratio_err = (vsew_next == EW64);
            LMUL_RSVD: ratio_err = 1'b1;
            default:   ratio_err = 1'b0;
        endcase
    end

    assign cfg_err = ratio_err | rsvd_err;

    // Elements per register at this SEW
    assign elems_per_reg = 32'(`VCFG_VLENB) >> vsew_next;

    // Scale by LMUL, fractional codes divide by 2^(8-code)
    always_comb begin
        if (vlmul_next[2]) begin
            vlmax = elems_per_reg >> (4'd8 - {1'b0, vlmul_next});
        end else begin
            vlmax = elems_per_reg << vlmul_next[1:0];
        end
    end

    // AVL selection, then clamp
    always_comb begin
        if (op_i.op == VSETIVLI) begin
            avl = {27'b0, op_i.rs1};
        end else if (op_i.rs1 == 5'd0 && op_i.rd != 5'd0) begin
            avl = vlmax;
        end else if (op_i.rs1 == 5'd0) begin
            // Keep current vl
            avl = vl_q;
        end else begin
            avl = op_i.rs1_val;
        end
        vl_next = (avl > vlmax) ? vlmax : avl;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vill_q  <= 1'b0;
            vma_q   <= 1'b0;
            vta_q   <= 1'b0;
            vsew_q  <= EW8;
            vlmul_q <= LMUL_1;
            vl_q    <= '0;
        end else if (is_vset) begin
            vill_q  <= cfg_err;
            vma_q   <= vma_next;
            vta_q   <= vta_next;
            vsew_q  <= vsew_next;
            vlmul_q <= vlmul_next;
            vl_q    <= cfg_err ? '0 : vl_next;
        end
    end

    assign vl_o    = vl_q;
    assign vtype_o = vill_q ? 32'h8000_0000 : {24'b0, vma_q, vta_q, vsew_q, vlmul_q};

    // CSR reads see state before this instruction's update
    always_comb begin
        if (op_i.op == CSR_READ) begin
            case (op_i.csr)
                VL:      wb_data = vl_q;
                VTYPE:   wb_data = vtype_o;
                VLENB:   wb_data = 32'(`VCFG_VLENB);
                default: wb_data = '0;
            endcase
        end else begin
            wb_data = cfg_err ? '0 : vl_next;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= (op_i.op != VOP_NONE) && (op_i.rd != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        wb_addr_q <= op_i.rd;
        wb_data_q <= wb_data;
    end

    assign wb_o = '{valid: wb_valid_q, addr: wb_addr_q, data: wb_data_q};

endmodule

`default_nettype wire

// ==== vset_decoder.sv ====
`default_nettype none

module vset_decoder (
    input  logic               instr_valid_i,
    input  logic [31:0]        instr_i,
    output logic [4:0]         rs1_addr_o,
    output logic [4:0]         rs2_addr_o,
    input  logic [31:0]        rs1_data_i,
    input  logic [31:0]        rs2_data_i,
    output vcfg_pkg::vcfg_op_t op_o
);
    import vcfg_pkg::*;

    localparam logic [6:0] OPC_VECTOR = 7'b1010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  rs1_field;
    logic [11:0] csr_addr;
    logic        is_vcfg;
    logic        is_csrrs;

    // Standard R/I field positions
    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign rs1_field = instr_i[19:15];
    assign csr_addr  = instr_i[31:20];

    // Operand addresses go straight to the register file
    assign rs1_addr_o = rs1_field;
    assign rs2_addr_o = instr_i[24:20];

    assign is_vcfg  = (opcode == OPC_VECTOR) && (funct3 == 3'b111);
    // csrrs with rs1 = x0, a pure read
    assign is_csrrs = (opcode == OPC_SYSTEM) && (funct3 == 3'b010) && (rs1_field == 5'd0);

    always_comb begin
        op_o         = '0;
        op_o.op      = VOP_NONE;
        op_o.rd      = instr_i[11:7];
        op_o.rs1     = rs1_field;
        op_o.rs1_val = rs1_data_i;
        op_o.rs2_val = rs2_data_i;
        op_o.csr     = VL;
        if (instr_valid_i) begin
            if (is_vcfg) begin
                if (!instr_i[31]) begin
                    op_o.op  = VSETVLI;
                    op_o.imm = instr_i[30:20];
                end else if (instr_i[31:30] == 2'b11) begin
                    // uimm AVL sits in the rs1 field
                    op_o.op  = VSETIVLI;
                    op_o.imm = {1'b0, instr_i[29:20]};
                end else if (instr_i[31:25] == 7'b1000000) begin
                    // vtype comes from rs2 value
                    op_o.op = VSETVL;
                end
            end else if (is_csrrs) begin
                case (csr_addr)
                    12'hC20: begin
                        op_o.op  = CSR_READ;
                        op_o.csr = VL;
                    end
                    12'hC21: begin
                        op_o.op  = CSR_READ;
                        op_o.csr = VTYPE;
                    end
                    12'hC22: begin
                        op_o.op  = CSR_READ;
                        op_o.csr = VLENB;
                    end
                    default: op_o.op = VOP_NONE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== vcfg_pkg.sv ====
`default_nettype none

package vcfg_pkg;

    // SEW encoding, vtype bits 5..3
    typedef enum logic [2:0] {
        EW8  = 3'd0,
        EW16 = 3'd1,
        EW32 = 3'd2,
        EW64 = 3'd3
    } vew_e;

    // LMUL encoding, vtype bits 2..0
    typedef enum logic [2:0] {
        LMUL_1    = 3'd0,
        LMUL_2    = 3'd1,
        LMUL_4    = 3'd2,
        LMUL_8    = 3'd3,
        LMUL_RSVD = 3'd4,
        LMUL_1_8  = 3'd5,
        LMUL_1_4  = 3'd6,
        LMUL_1_2  = 3'd7
    } vlmul_e;

    // Recognized instruction kinds
    typedef enum logic [2:0] {
        VOP_NONE = 3'd0,
        VSETVLI  = 3'd1,
        VSETIVLI = 3'd2,
        VSETVL   = 3'd3,
        CSR_READ = 3'd4
    } vop_e;

    // Readable vector CSRs
    typedef enum logic [1:0] {
        VL    = 2'd0,
        VTYPE = 2'd1,
        VLENB = 2'd2
    } vcsr_e;

    // Decoder output, operand values already read
    typedef struct packed {
        vop_e        op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [10:0] imm;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        vcsr_e       csr;
    } vcfg_op_t;

    // One register-file write
    typedef struct packed {
        logic        valid;
        logic [4:0]  addr;
        logic [31:0] data;
    } wb_req_t;

endpackage

`default_nettype wire

// ==== vcfg_settings.svh ====
`ifndef VCFG_SETTINGS_SVH
`define VCFG_SETTINGS_SVH

// Vector register length in bits (64, 128 or 256)
`define VCFG_VLEN 64

// Same length in bytes, also the vlenb CSR value
`define VCFG_VLENB (`VCFG_VLEN / 8)

// Scalar register count
`define VCFG_NREGS 32

`endif
